// ==== all.f ====
+incdir+src
src/vsu_pkg.sv
src/vsu_cmd_decode.sv
src/vsu_elem_fifo.sv
src/vsu_write_streamer.sv
src/vmem_store_unit.sv
sim/tb_vmem_store_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the vector store unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f all.f \
  --top-module tb_vmem_store_unit -Mdir obj_dir \
  && ./obj_dir/Vtb_vmem_store_unit \
  || { echo "Simulation did not pass"; exit 1; }

// ==== sim/tb_vmem_store_unit.sv ====
/*
  Directed testbench for the vector store unit: clock and reset,
  lane and write-channel models, store and illegal-command tests
*/
`timescale 1ns/1ps
`include "vsu_params.svh"

module tb_vmem_store_unit;

  localparam int TIMEOUT_CYCLES = 2000;

  logic                  clk;
  logic                  rstn;
  logic                  cmd_valid;
  logic                  cmd_ready;
  vsu_pkg::vsu_mode_e    cmd_mode;
  vsu_pkg::vsu_sew_t     cmd_sew;
  vsu_pkg::vsu_sew_t     cmd_eew;
  vsu_pkg::vsu_lmul_t    cmd_lmul;
  vsu_pkg::vsu_addr_t    cmd_base;
  vsu_pkg::vsu_addr_t    cmd_stride;
  logic                  lane_valid;
  logic                  lane_ready;
  vsu_pkg::vsu_data_t    lane_data;
  logic                  wr_valid;
  logic                  wr_ready;
  vsu_pkg::vsu_addr_t    wr_addr;
  vsu_pkg::vsu_data_t    wr_data;
  vsu_pkg::vsu_sew_t     wr_size;
  logic                  wr_last;
  logic                  done;
  logic                  cmd_err;
  integer                seed;

  vmem_store_unit dut0 (
    .clk          (clk),
    .rstn         (rstn),
    .cmd_valid_i  (cmd_valid),
    .cmd_ready_o  (cmd_ready),
    .cmd_mode_i   (cmd_mode),
    .cmd_sew_i    (cmd_sew),
    .cmd_eew_i    (cmd_eew),
    .cmd_lmul_i   (cmd_lmul),
    .cmd_base_i   (cmd_base),
    .cmd_stride_i (cmd_stride),
    .lane_valid_i (lane_valid),
    .lane_ready_o (lane_ready),
    .lane_data_i  (lane_data),
    .wr_valid_o   (wr_valid),
    .wr_ready_i   (wr_ready),
    .wr_addr_o    (wr_addr),
    .wr_data_o    (wr_data),
    .wr_size_o    (wr_size),
    .wr_last_o    (wr_last),
    .done_o       (done),
    .cmd_err_o    (cmd_err)
  );

  always #50 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Failure reporting and reference rules
  //////////////////////////////////////////////////////////////////////

  task automatic abort_sim(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic mismatch(input string msg);
    abort_sim($sformatf("ERR %0t: %s", $time, msg));
  endtask

  task automatic timed_out(input string what);
    abort_sim($sformatf("Timeout: no %s within %0d cycles", what, TIMEOUT_CYCLES));
  endtask

  function automatic int rand_pct();
    return int'($unsigned($random(seed)) % 100);
  endfunction

  // VL = VLEN * LMUL / SEW
  function automatic int expected_vl(input logic [2:0] sew, input logic [2:0] lmul);
    int num;
    int den;
    num = 1;
    den = 1;
    if (lmul < 3'd4) begin
      num = 1 << lmul;
    end else begin
      den = 1 << (8 - int'(lmul));
    end
    return (`VSU_VLEN * num) / ((8 << sew) * den);
  endfunction

  function automatic bit cmd_is_legal(input logic [2:0] sew, input logic [2:0] eew,
                                      input logic [2:0] lmul);
    int lmul_log;
    int emul_log;
    lmul_log = (lmul < 3'd4) ? int'(lmul) : int'(lmul) - 8;
    emul_log = int'(eew) - int'(sew) + lmul_log;
    if (sew > 3'd3 || eew > 3'd3 || lmul == 3'd4) begin
      return 1'b0;
    end
    return (emul_log >= -3) && (emul_log <= 3) && (expected_vl(sew, lmul) >= 1);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Command issue and directed tests
  //////////////////////////////////////////////////////////////////////

  // Returns on the edge where the command is taken
  task automatic send_cmd(input vsu_pkg::vsu_mode_e mode, input logic [2:0] sew,
                          input logic [2:0] eew, input logic [2:0] lmul,
                          input vsu_pkg::vsu_addr_t base, input vsu_pkg::vsu_addr_t stride);
    int waited;
    waited = 0;
    @(posedge clk);
    cmd_valid  <= 1'b1;
    cmd_mode   <= mode;
    cmd_sew    <= sew;
    cmd_eew    <= eew;
    cmd_lmul   <= lmul;
    cmd_base   <= base;
    cmd_stride <= stride;
    @(negedge clk);
    while (!cmd_ready) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        timed_out("command handshake");
      end
      @(negedge clk);
    end
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  // Legal store with lane valid and write ready drawn at the given percentages
  task automatic run_store(input vsu_pkg::vsu_mode_e mode, input logic [2:0] sew,
                           input logic [2:0] eew, input logic [2:0] lmul,
                           input vsu_pkg::vsu_addr_t base, input vsu_pkg::vsu_addr_t stride,
                           input int lane_pct, input int wr_pct);
    int                  vl;
    int                  beats;
    int                  pushed;
    int                  cycles;
    logic                lane_fire;
    logic                beat_fire;
    vsu_pkg::vsu_addr_t  step;
    vsu_pkg::vsu_addr_t  exp_addr;
    vsu_pkg::vsu_data_t  elems[$];
    vl = expected_vl(sew, lmul);
    assert (cmd_is_legal(sew, eew, lmul)) else abort_sim("Store test given an illegal command");
    // One spare element so the lane keeps offering past VL
    for (int i = 0; i <= vl; i++) begin
      elems.push_back({$random(seed), $random(seed)});
    end
    step = (mode == vsu_pkg::MODE_STRIDED) ? stride : vsu_pkg::vsu_addr_t'(1) << eew;
    send_cmd(mode, sew, eew, lmul, base, stride);
    beats  = 0;
    pushed = 0;
    cycles = 0;
    while (beats < vl) begin
      lane_valid <= (rand_pct() < lane_pct);
      lane_data  <= elems[pushed];
      wr_ready   <= (rand_pct() < wr_pct);
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        timed_out("store completion");
      end
      lane_fire = lane_valid && lane_ready;
      beat_fire = wr_valid && wr_ready;
      assert (!cmd_ready) else mismatch("cmd_ready high while a store is active");
      assert (!cmd_err) else mismatch("cmd_err on a legal command");
      assert (done == (beat_fire && beats == vl - 1))
        else mismatch($sformatf("done %b on beat %0d of %0d, taken %b", done, beats, vl, beat_fire));
      if (beat_fire) begin
        exp_addr = base + vsu_pkg::vsu_addr_t'(beats) * step;
        assert (beats < pushed)
          else mismatch($sformatf("beat %0d sent before its element arrived", beats));
        assert (wr_addr == exp_addr)
          else mismatch($sformatf("beat %0d address %h, expected %h", beats, wr_addr, exp_addr));
        assert (wr_data == elems[beats])
          else mismatch($sformatf("beat %0d data %h, expected %h", beats, wr_data, elems[beats]));
        assert (wr_size == eew)
          else mismatch($sformatf("beat %0d size %0d, expected %0d", beats, wr_size, eew));
        assert (wr_last == (beats == vl - 1))
          else mismatch($sformatf("beat %0d of %0d has last %b", beats, vl, wr_last));
        beats++;
      end
      if (lane_fire) begin
        pushed++;
        assert (pushed <= vl)
          else mismatch($sformatf("lane admitted %0d elements, VL is %0d", pushed, vl));
      end
      @(posedge clk);
    end
    lane_valid <= 1'b0;
    wr_ready   <= 1'b0;
    @(negedge clk);
    assert (cmd_ready) else mismatch("cmd_ready low after done");
    assert (!wr_valid && !done) else mismatch("write activity after done");
  endtask

  // Rejected command, then a few quiet cycles with the lane pushing
  task automatic run_illegal(input logic [2:0] sew, input logic [2:0] eew,
                             input logic [2:0] lmul);
    assert (!cmd_is_legal(sew, eew, lmul)) else abort_sim("Illegal test given a legal command");
    send_cmd(vsu_pkg::MODE_UNIT, sew, eew, lmul, 32'h0000_2000, 32'h0);
    lane_valid <= 1'b1;
    wr_ready   <= 1'b1;
    @(negedge clk);
    assert (cmd_err) else mismatch("no cmd_err one cycle after an illegal command");
    assert (!cmd_ready && !wr_valid && !lane_ready) else mismatch("activity on cmd_err cycle");
    for (int i = 0; i < 6; i++) begin
      @(negedge clk);
      assert (!cmd_err && !done) else mismatch("cmd_err or done repeated");
      assert (!wr_valid && !lane_ready) else mismatch("lane or write active after cmd_err");
      assert (cmd_ready) else mismatch("cmd_ready not back after cmd_err");
    end
    @(posedge clk);
    lane_valid <= 1'b0;
    wr_ready   <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed       = 32'hded9_e215;
    clk        = 1'b0;
    rstn       = 1'b0;
    cmd_valid  = 1'b0;
    cmd_mode   = vsu_pkg::MODE_UNIT;
    cmd_sew    = '0;
    cmd_eew    = '0;
    cmd_lmul   = '0;
    cmd_base   = '0;
    cmd_stride = '0;
    lane_valid = 1'b0;
    lane_data  = '0;
    wr_ready   = 1'b0;
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    assert (!wr_valid && !lane_ready && !done && !cmd_err) else mismatch("outputs set after reset");
    assert (cmd_ready) else mismatch("cmd_ready low after reset");

    // SEW 32, LMUL 1, EEW 32, eight beats
    run_store(vsu_pkg::MODE_UNIT, 3'd2, 3'd2, 3'd0, 32'h0000_1000, 32'h0, 100, 100);
    // Strided, LMUL 2, crossing the top of the address space
    run_store(vsu_pkg::MODE_STRIDED, 3'd2, 3'd2, 3'd1, 32'hffff_fe00, 32'h40, 100, 100);

    run_illegal(3'd2, 3'd2, 3'd4);
    // EMUL 4 and EMUL -4
    run_illegal(3'd0, 3'd3, 3'd1);
    run_illegal(3'd3, 3'd0, 3'd7);
    // VL rounds down to zero
    run_illegal(3'd3, 3'd3, 3'd5);

    // Slow lane and write stalls
    run_store(vsu_pkg::MODE_UNIT, 3'd0, 3'd1, 3'd0, 32'h8000_0010, 32'h0, 40, 50);
    run_store(vsu_pkg::MODE_STRIDED, 3'd1, 3'd1, 3'd2, 32'h0000_0100, 32'hffff_fff8, 60, 30);

    // Fractional LMUL, back to back
    run_store(vsu_pkg::MODE_UNIT, 3'd0, 3'd0, 3'd5, 32'h0000_4000, 32'h0, 100, 100);
    run_store(vsu_pkg::MODE_STRIDED, 3'd0, 3'd0, 3'd5, 32'h0000_5000, 32'h10, 100, 100);
    run_store(vsu_pkg::MODE_UNIT, 3'd1, 3'd0, 3'd7, 32'h0000_6003, 32'h0, 70, 70);

    $display("Test completed successfully");
    $finish;
  end

endmodule : tb_vmem_store_unit

// ==== src/vmem_store_unit.sv ====
/*
  Vector store unit top: command decoder, element FIFO, write streamer
*/
`timescale 1ns/1ps

module vmem_store_unit (
  input  logic                  clk,
  input  logic                  rstn,
  // Scheduler command
  input  logic                  cmd_valid_i,
  output logic                  cmd_ready_o,
  input  vsu_pkg::vsu_mode_e    cmd_mode_i,
  input  vsu_pkg::vsu_sew_t     cmd_sew_i,
  input  vsu_pkg::vsu_sew_t     cmd_eew_i,
  input  vsu_pkg::vsu_lmul_t    cmd_lmul_i,
  input  vsu_pkg::vsu_addr_t    cmd_base_i,
  input  vsu_pkg::vsu_addr_t    cmd_stride_i,
  // Vector lane
  input  logic                  lane_valid_i,
  output logic                  lane_ready_o,
  input  vsu_pkg::vsu_data_t    lane_data_i,
  // Write channel
  output logic                  wr_valid_o,
  input  logic                  wr_ready_i,
  output vsu_pkg::vsu_addr_t    wr_addr_o,
  output vsu_pkg::vsu_data_t    wr_data_o,
  output vsu_pkg::vsu_sew_t     wr_size_o,
  output logic                  wr_last_o,
  // Status
  output logic                  done_o,
  output logic                  cmd_err_o
);

  logic                store_start;
  logic                store_done;
  vsu_pkg::vsu_cnt_t   elem_cnt;
  vsu_pkg::vsu_addr_t  base_addr;
  vsu_pkg::vsu_addr_t  addr_step;
  vsu_pkg::vsu_sew_t   elem_size;
  vsu_pkg::vsu_data_t  fifo_head;
  logic                fifo_not_empty;
  logic                fifo_pop;

  assign done_o = store_done;

  vsu_cmd_decode u_dec (
    .clk           (clk),
    .rstn          (rstn),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_ready_o   (cmd_ready_o),
    .cmd_mode_i    (cmd_mode_i),
    .cmd_sew_i     (cmd_sew_i),
    .cmd_eew_i     (cmd_eew_i),
    .cmd_lmul_i    (cmd_lmul_i),
    .cmd_base_i    (cmd_base_i),
    .cmd_stride_i  (cmd_stride_i),
    .cmd_err_o     (cmd_err_o),
    .store_start_o (store_start),
    .elem_cnt_o    (elem_cnt),
    .base_addr_o   (base_addr),
    .addr_step_o   (addr_step),
    .elem_size_o   (elem_size),
    .store_done_i  (store_done)
  );

  vsu_elem_fifo u_fifo (
    .clk           (clk),
    .rstn          (rstn),
    .store_start_i (store_start),
    .elem_cnt_i    (elem_cnt),
    .lane_valid_i  (lane_valid_i),
    .lane_ready_o  (lane_ready_o),
    .lane_data_i   (lane_data_i),
    .pop_i         (fifo_pop),
    .head_o        (fifo_head),
    .not_empty_o   (fifo_not_empty)
  );

  vsu_write_streamer u_wr (
    .clk           (clk),
    .rstn          (rstn),
    .store_start_i (store_start),
    .elem_cnt_i    (elem_cnt),
    .base_addr_i   (base_addr),
    .addr_step_i   (addr_step),
    .elem_size_i   (elem_size),
    .head_i        (fifo_head),
    .not_empty_i   (fifo_not_empty),
    .pop_o         (fifo_pop),
    .wr_valid_o    (wr_valid_o),
    .wr_ready_i    (wr_ready_i),
    .wr_addr_o     (wr_addr_o),
    .wr_data_o     (wr_data_o),
    .wr_size_o     (wr_size_o),
    .wr_last_o     (wr_last_o),
    .store_done_o  (store_done)
  );

endmodule : vmem_store_unit

// ==== src/vsu_cmd_decode.sv ====
/*
  Store command decoder: command handshake, EMUL legality check,
  element count and address step, busy tracking of the running store
*/
`timescale 1ns/1ps
`include "vsu_params.svh"

module vsu_cmd_decode (
  input  logic                    clk,
  input  logic                    rstn,
  // Scheduler command
  input  logic                    cmd_valid_i,
  output logic                    cmd_ready_o,
  input  vsu_pkg::vsu_mode_e      cmd_mode_i,
  input  vsu_pkg::vsu_sew_t       cmd_sew_i,
  input  vsu_pkg::vsu_sew_t       cmd_eew_i,
  input  vsu_pkg::vsu_lmul_t      cmd_lmul_i,
  input  vsu_pkg::vsu_addr_t      cmd_base_i,
  input  vsu_pkg::vsu_addr_t      cmd_stride_i,
  output logic                    cmd_err_o,
  // Store setup towards FIFO and streamer
  output logic                    store_start_o,
  output vsu_pkg::vsu_cnt_t       elem_cnt_o,
  output vsu_pkg::vsu_addr_t      base_addr_o,
  output vsu_pkg::vsu_addr_t      addr_step_o,
  output vsu_pkg::vsu_sew_t       elem_size_o,
  input  logic                    store_done_i
);

  // Elements in one register at SEW 8
  localparam int unsigned VL_SEW8 = `VSU_VLEN / 8;

  vsu_pkg::vsu_dec_state_e state_q, state_d;

  logic                    accept;
  logic                    legal;
  logic signed [4:0]       emul;
  logic [2:0]              lmul_frac_sh;
  vsu_pkg::vsu_cnt_t       vl_sew;
  vsu_pkg::vsu_cnt_t       vl;
  vsu_pkg::vsu_addr_t      step;

  logic                    start_q;
  logic                    err_q;
  vsu_pkg::vsu_cnt_t       cnt_q;
  vsu_pkg::vsu_addr_t      base_q;
  vsu_pkg::vsu_addr_t      step_q;
  vsu_pkg::vsu_sew_t       size_q;

  assign cmd_ready_o = (state_q == vsu_pkg::DEC_IDLE);
  assign accept      = cmd_valid_i && cmd_ready_o;

  //////////////////////////////////////////////////////////////////////
  // Legality and element count
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // log2(EEW/SEW) + log2(LMUL), LMUL code read as signed
    emul = $signed({3'b000, cmd_eew_i[1:0]}) - $signed({3'b000, cmd_sew_i[1:0]})
         + $signed({{2{cmd_lmul_i[2]}}, cmd_lmul_i});

    // VL = VLEN * LMUL / SEW
    lmul_frac_sh = 3'd0 - cmd_lmul_i;
    vl_sew       = vsu_pkg::vsu_cnt_t'(VL_SEW8) >> cmd_sew_i[1:0];
    if (cmd_lmul_i[2]) begin
      vl = vl_sew >> lmul_frac_sh;
    end else begin
      vl = vl_sew << cmd_lmul_i[1:0];
    end

    legal = !cmd_sew_i[2] && !cmd_eew_i[2] && (cmd_lmul_i != 3'd4) &&
            (emul >= -5'sd3) && (emul <= 5'sd3) && (vl != '0);

    // Unit stride walks by one element of EEW bytes
    if (cmd_mode_i == vsu_pkg::MODE_STRIDED) begin
      step = cmd_stride_i;
    end else begin
      step = vsu_pkg::vsu_addr_t'(1) << cmd_eew_i[1:0];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      vsu_pkg::DEC_IDLE: begin
        if (accept) begin
          state_d = vsu_pkg::DEC_ACTIVE;
        end
      end
      vsu_pkg::DEC_ACTIVE: begin
        // Rejected command or last beat accepted
        if (err_q || store_done_i) begin
          state_d = vsu_pkg::DEC_IDLE;
        end
      end
      default: state_d = vsu_pkg::DEC_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q <= vsu_pkg::DEC_IDLE;
      start_q <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      start_q <= accept && legal;
      err_q   <= accept && !legal;
    end
  end

  // Command result, held for the whole store
  always_ff @(posedge clk) begin
    if (accept) begin
      cnt_q  <= vl;
      base_q <= cmd_base_i;
      step_q <= step;
      size_q <= cmd_eew_i;
    end
  end

  assign store_start_o = start_q;
  assign cmd_err_o     = err_q;
  assign elem_cnt_o    = cnt_q;
  assign base_addr_o   = base_q;
  assign addr_step_o   = step_q;
  assign elem_size_o   = size_q;

  // Completion only for a store that was started earlier
  a_done_when_active : assert property (@(posedge clk) disable iff (!rstn)
    store_done_i |-> (state_q == vsu_pkg::DEC_ACTIVE) && !start_q);

endmodule : vsu_cmd_decode

// ==== src/vsu_elem_fifo.sv ====
/*
  Element FIFO between the vector lane and the write streamer,
  with per-store admission limit on the lane side
*/
`timescale 1ns/1ps
`include "vsu_params.svh"

module vsu_elem_fifo (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  store_start_i,
  input  vsu_pkg::vsu_cnt_t     elem_cnt_i,
  // Lane side
  input  logic                  lane_valid_i,
  output logic                  lane_ready_o,
  input  vsu_pkg::vsu_data_t    lane_data_i,
  // Streamer side
  input  logic                  pop_i,
  output vsu_pkg::vsu_data_t    head_o,
  output logic                  not_empty_o
);

  localparam int unsigned DEPTH = `VSU_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  vsu_pkg::vsu_data_t   mem [DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [CNT_W-1:0]     count_q;
  vsu_pkg::vsu_cnt_t    remain_q;
  logic                 full;
  logic                 push;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Lane is held off when full or when all VL elements are in
  assign full         = (count_q == CNT_W'(DEPTH));
  assign lane_ready_o = !full && (remain_q != '0);
  assign push         = lane_valid_i && lane_ready_o;

  assign not_empty_o  = (count_q != '0);
  assign head_o       = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr_q] <= lane_data_i;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      remain_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // Elements still expected from the lane for this store
      if (store_start_i) begin
        remain_q <= elem_cnt_i;
      end else if (push) begin
        remain_q <= remain_q - 1'b1;
      end
    end
  end

  a_no_pop_empty : assert property (@(posedge clk) disable iff (!rstn)
    pop_i |-> not_empty_o);

  // New store begins on a drained FIFO with the previous lane count used up
  a_start_drained : assert property (@(posedge clk) disable iff (!rstn)
    store_start_i |-> !not_empty_o && (remain_q == '0));

endmodule : vsu_elem_fifo

// ==== src/vsu_params.svh ====
/*
  Global sizing macros for the vector store unit:
  vector length, data and address widths, FIFO depth, counter width
*/
`ifndef VSU_PARAMS_SVH
`define VSU_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// Vector register geometry
//////////////////////////////////////////////////////////////////////

// Vector register length in bits
`define VSU_VLEN        256

// Element width on the lane and on the write channel
`define VSU_DATA_W      64

// Byte address width of the write channel
`define VSU_ADDR_W      32

// Elements buffered between lane and write channel
`define VSU_FIFO_DEPTH  4

// Holds VLEN/8 * 8 elements plus one
`define VSU_CNT_W       ($clog2(`VSU_VLEN) + 1)

`endif

// ==== src/vsu_pkg.sv ====
/*
  Shared types of the vector store unit:
  store opcode and decoder state enums, field and payload types
*/
`include "vsu_params.svh"

package vsu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Opcodes and states
  //////////////////////////////////////////////////////////////////////

  // Store addressing mode
  typedef enum logic {
    MODE_UNIT    = 1'b0,
    MODE_STRIDED = 1'b1
  } vsu_mode_e;

  // Command decoder FSM
  typedef enum logic {
    DEC_IDLE   = 1'b0,
    DEC_ACTIVE = 1'b1
  } vsu_dec_state_e;

  //////////////////////////////////////////////////////////////////////
  // Field types
  //////////////////////////////////////////////////////////////////////

  // Width code, 0..3 map to 8/16/32/64 bits, 4..7 illegal
  typedef logic [2:0] vsu_sew_t;

  // LMUL code, 0..3 are 1/2/4/8, 5..7 are 1/8..1/2, 4 reserved
  // Read as signed it is log2(LMUL)
  typedef logic [2:0] vsu_lmul_t;

  // Element counters
  typedef logic [`VSU_CNT_W-1:0] vsu_cnt_t;

  // Byte addresses and element payload
  typedef logic [`VSU_ADDR_W-1:0] vsu_addr_t;
  typedef logic [`VSU_DATA_W-1:0] vsu_data_t;

endpackage : vsu_pkg

// ==== src/vsu_write_streamer.sv ====
/*
  Write streamer: one write beat per buffered element,
  running address, last-beat flag and store completion
*/
`timescale 1ns/1ps

module vsu_write_streamer (
  input  logic                  clk,
  input  logic                  rstn,
  // Store setup from the decoder
  input  logic                  store_start_i,
  input  vsu_pkg::vsu_cnt_t     elem_cnt_i,
  input  vsu_pkg::vsu_addr_t    base_addr_i,
  input  vsu_pkg::vsu_addr_t    addr_step_i,
  input  vsu_pkg::vsu_sew_t     elem_size_i,
  // FIFO head
  input  vsu_pkg::vsu_data_t    head_i,
  input  logic                  not_empty_i,
  output logic                  pop_o,
  // Write channel
  output logic                  wr_valid_o,
  input  logic                  wr_ready_i,
  output vsu_pkg::vsu_addr_t    wr_addr_o,
  output vsu_pkg::vsu_data_t    wr_data_o,
  output vsu_pkg::vsu_sew_t     wr_size_o,
  output logic                  wr_last_o,
  output logic                  store_done_o
);

  vsu_pkg::vsu_addr_t  addr_q;
  vsu_pkg::vsu_cnt_t   remain_q;
  logic                beat;

  //////////////////////////////////////////////////////////////////////
  // Beat generation
  //////////////////////////////////////////////////////////////////////

  // Any buffered element is offered straight away
  assign wr_valid_o = not_empty_i;
  assign beat       = wr_valid_o && wr_ready_i;

  // Head leaves the FIFO only once the beat is taken
  assign pop_o      = beat;

  assign wr_addr_o  = addr_q;
  assign wr_data_o  = head_i;
  assign wr_size_o  = elem_size_i;
  assign wr_last_o  = (remain_q == vsu_pkg::vsu_cnt_t'(1));

  assign store_done_o = beat && wr_last_o;

  //////////////////////////////////////////////////////////////////////
  // Address and beat counters
  //////////////////////////////////////////////////////////////////////

  // base + k*step, wraps at the address width
  always_ff @(posedge clk) begin
    if (store_start_i) begin
      addr_q <= base_addr_i;
    end else if (beat) begin
      addr_q <= addr_q + addr_step_i;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      remain_q <= '0;
    end else if (store_start_i) begin
      remain_q <= elem_cnt_i;
    end else if (beat) begin
      remain_q <= remain_q - 1'b1;
    end
  end

  // Stalled beat keeps its address and FIFO head
  a_stall_stable : assert property (@(posedge clk) disable iff (!rstn)
    wr_valid_o && !wr_ready_i |=> wr_valid_o && $stable(wr_addr_o) && $stable(wr_data_o));

endmodule : vsu_write_streamer
